// File: Bender.yml
package:
  name: rv_datapath

export_include_dirs:
  - source

sources:
  - files:
      - source/rv_pipe_pkg.sv
      - source/decode_stage.sv
      - source/exe_stage.sv
      - source/exe_mem_reg.sv
      - source/mem_stage.sv
      - source/rv_datapath.sv
  - target: test
    files:
      - tb/rv_datapath_checker.sv
      - tb/rv_datapath_tb.sv

// File: source/decode_stage.sv
`timescale 1ns/1ps
`include "rv_pipe_params.svh"

module decode_stage
    import rv_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     instr_req_i,
    input  rv_word_t instr_i,
    output logic     instr_ack_o,
    input  logic     retire_valid_i,
    input  retire_t  retire_i,
    input  logic     buf_rdy_i,
    output logic     issue_valid_o,
    output issue_t   issue_o
);

    hs_state_e               hs_q;
    rv_word_t                rf_q [`RV_NUM_REGS];
    logic [`RV_NUM_REGS-1:0] sb_q;
    logic [`RV_NUM_REGS-1:0] sb_set;
    logic [`RV_NUM_REGS-1:0] sb_clr;
    logic [`RV_NUM_REGS-1:0] pend;

    rv_opcode_e opcode;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_e    op;
    rv_word_t   imm;
    logic       use_imm;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       writes_rd;
    logic       rd_we;
    logic       wr_en;
    logic       hazard;
    logic       accept;
    rv_word_t   rs1_val;
    rv_word_t   rs2_val;

    assign opcode = rv_opcode_e'(instr_i[6:0]);
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign funct7 = instr_i[31:25];

    always_comb begin
        op        = OP_NOP;
        imm       = '0;
        use_imm   = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
            OPC_REG: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  op = OP_ADD;
                        3'b010:  op = OP_SLT;
                        3'b100:  op = OP_XOR;
                        3'b110:  op = OP_OR;
                        3'b111:  op = OP_AND;
                        default: op = OP_NOP;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    op = OP_SUB;
                end
                uses_rs1  = (op != OP_NOP);
                uses_rs2  = (op != OP_NOP);
                writes_rd = (op != OP_NOP);
            end
            OPC_IMM: begin
                if (funct3 == 3'b000) begin // addi only
                    op        = OP_ADD;
                    imm       = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]};
                    use_imm   = 1'b1;
                    uses_rs1  = 1'b1;
                    writes_rd = 1'b1;
                end
            end
            OPC_LUI: begin
                op        = OP_LUI;
                imm       = {instr_i[31:12], 12'b0};
                writes_rd = 1'b1;
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin // lw
                    op        = OP_LOAD;
                    imm       = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]};
                    use_imm   = 1'b1;
                    uses_rs1  = 1'b1;
                    writes_rd = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin // sw
                    op       = OP_STORE;
                    imm      = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                    use_imm  = 1'b1;
                    uses_rs1 = 1'b1;
                    uses_rs2 = 1'b1;
                end
            end
            default: op = OP_NOP;
        endcase
    end

    assign rd_we = writes_rd && (rd != '0); // x0 never tracked
    assign wr_en = retire_valid_i && retire_i.rd_we && (retire_i.rd != '0);

    // a retiring register is free this cycle, its value bypasses the array
    always_comb begin
        sb_clr = '0;
        sb_set = '0;
        if (wr_en) begin
            sb_clr[retire_i.rd] = 1'b1;
        end
        if (accept && rd_we) begin
            sb_set[rd] = 1'b1;
        end
    end

    assign pend    = sb_q & ~sb_clr;
    assign hazard  = (uses_rs1 && pend[rs1]) || (uses_rs2 && pend[rs2]) || (rd_we && pend[rd]);
    assign accept  = (hs_q == HS_IDLE) && instr_req_i && !hazard
                     && (!issue_valid_o || buf_rdy_i);
    assign rs1_val = (wr_en && retire_i.rd == rs1) ? retire_i.data : rf_q[rs1];
    assign rs2_val = (wr_en && retire_i.rd == rs2) ? retire_i.data : rf_q[rs2];

    assign instr_ack_o = (hs_q == HS_ACK);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hs_q          <= HS_IDLE;
            issue_valid_o <= 1'b0;
            sb_q          <= '0;
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                rf_q[i] <= '0;
            end
        end else begin
            case (hs_q)
                HS_IDLE: if (accept) hs_q <= HS_ACK;
                HS_ACK:  if (!instr_req_i) hs_q <= HS_IDLE; // source released req
                default: hs_q <= HS_IDLE;
            endcase
            if (accept) begin
                issue_valid_o <= 1'b1;
            end else if (buf_rdy_i) begin
                issue_valid_o <= 1'b0; // drained into buffer
            end
            sb_q <= pend | sb_set;
            if (wr_en) begin
                rf_q[retire_i.rd] <= retire_i.data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue_o.op      <= op;
            issue_o.rs1_val <= rs1_val;
            issue_o.rs2_val <= rs2_val;
            issue_o.imm     <= imm;
            issue_o.rd      <= rd;
            issue_o.rd_we   <= rd_we;
            issue_o.use_imm <= use_imm;
        end
    end

endmodule

// File: source/exe_mem_reg.sv
`timescale 1ns/1ps
`include "rv_pipe_params.svh"

module exe_mem_reg
    import rv_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     push_i,
    input  exe_mem_t entry_i,
    output logic     rdy_o,
    output logic     head_valid_o,
    output exe_mem_t head_o,
    input  logic     pop_i
);

    localparam int DEPTH = `RV_BUF_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(DEPTH);

    exe_mem_t         buf_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign rdy_o        = (count_q != FULL); // full blocks issue
    assign head_valid_o = (count_q != '0);
    assign head_o       = buf_q[rd_ptr_q];

    assign do_push = push_i && rdy_o;
    assign do_pop  = pop_i && head_valid_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // idle or push+pop
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            buf_q[wr_ptr_q] <= entry_i;
        end
    end

endmodule

// File: source/exe_stage.sv
`timescale 1ns/1ps
`include "rv_pipe_params.svh"

module exe_stage
    import rv_pipe_pkg::*;
(
    input  issue_t   issue_i,
    output exe_mem_t result_o
);

    rv_word_t opb;
    rv_word_t alu_res;
    logic     lt;

    assign opb = issue_i.use_imm ? issue_i.imm : issue_i.rs2_val;
    assign lt  = $signed(issue_i.rs1_val) < $signed(opb);

    always_comb begin
        case (issue_i.op)
            OP_ADD, OP_LOAD, OP_STORE: begin
                alu_res = issue_i.rs1_val + opb; // also the word address
            end
            OP_SUB: begin
                alu_res = issue_i.rs1_val - opb;
            end
            OP_AND: begin
                alu_res = issue_i.rs1_val & opb;
            end
            OP_OR: begin
                alu_res = issue_i.rs1_val | opb;
            end
            OP_XOR: begin
                alu_res = issue_i.rs1_val ^ opb;
            end
            OP_SLT: begin
                alu_res = {{(`RV_XLEN-1){1'b0}}, lt};
            end
            OP_LUI: begin
                alu_res = issue_i.imm; // already shifted in decode
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

    always_comb begin
        result_o.op         = issue_i.op;
        result_o.result     = alu_res;
        result_o.store_data = issue_i.rs2_val;
        result_o.rd         = issue_i.rd;
        result_o.rd_we      = issue_i.rd_we;
    end

endmodule

// File: source/mem_stage.sv
`timescale 1ns/1ps

module mem_stage
    import rv_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     head_valid_i,
    input  exe_mem_t head_i,
    output logic     pop_o,
    output logic     dmem_req_o,
    output logic     dmem_we_o,
    output rv_word_t dmem_addr_o,
    output rv_word_t dmem_wdata_o,
    input  logic     dmem_ack_i,
    input  rv_word_t dmem_rdata_i,
    output logic     retire_valid_o,
    output retire_t  retire_o
);

    hs_state_e st_q;
    exe_mem_t  item_q; // load/store in flight
    logic      head_is_mem;
    logic      head_wr;
    logic      ack_seen;

    assign head_is_mem = (head_i.op == OP_LOAD) || (head_i.op == OP_STORE);
    assign head_wr     = head_i.rd_we && (head_i.op != OP_STORE) && (head_i.op != OP_NOP);
    assign pop_o       = head_valid_i && (st_q == HS_IDLE);
    assign ack_seen    = (st_q == HS_ACK) && dmem_ack_i;

    // request fields come straight from the held item
    assign dmem_we_o    = (item_q.op == OP_STORE);
    assign dmem_addr_o  = item_q.result;
    assign dmem_wdata_o = item_q.store_data;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            st_q           <= HS_IDLE;
            dmem_req_o     <= 1'b0;
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= 1'b0; // single-cycle pulse
            case (st_q)
                HS_IDLE: begin
                    if (pop_o) begin
                        if (head_is_mem) begin
                            st_q       <= HS_ACK;
                            dmem_req_o <= 1'b1;
                        end else begin
                            retire_valid_o <= 1'b1;
                        end
                    end
                end
                HS_ACK: begin
                    if (dmem_ack_i) begin
                        dmem_req_o     <= 1'b0;
                        retire_valid_o <= 1'b1;
                        st_q           <= HS_WAIT_LOW;
                    end
                end
                HS_WAIT_LOW: begin
                    if (!dmem_ack_i) begin
                        st_q <= HS_IDLE; // memory released ack
                    end
                end
                default: st_q <= HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            item_q         <= head_i;
            retire_o.rd    <= head_i.rd;
            retire_o.rd_we <= head_wr;
            retire_o.data  <= head_i.result;
        end else if (ack_seen) begin
            retire_o.rd    <= item_q.rd;
            retire_o.rd_we <= item_q.rd_we && (item_q.op == OP_LOAD);
            retire_o.data  <= dmem_we_o ? item_q.store_data : dmem_rdata_i;
        end
    end

endmodule

// File: source/rv_datapath.sv
`timescale 1ns/1ps

module rv_datapath
    import rv_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,

    input  logic     instr_req_i,
    input  rv_word_t instr_i,
    output logic     instr_ack_o,

    output logic     dmem_req_o,
    output logic     dmem_we_o,
    output rv_word_t dmem_addr_o,
    output rv_word_t dmem_wdata_o,
    input  logic     dmem_ack_i,
    input  rv_word_t dmem_rdata_i,

    output logic     retire_valid_o,
    output retire_t  retire_o
);

    logic     issue_valid;
    issue_t   issue;
    exe_mem_t exe_res;
    logic     buf_rdy;
    logic     head_valid;
    exe_mem_t head;
    logic     mem_pop;

    decode_stage decode (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .instr_req_i    (instr_req_i),
        .instr_i        (instr_i),
        .instr_ack_o    (instr_ack_o),
        .retire_valid_i (retire_valid_o), // writeback into the register file
        .retire_i       (retire_o),
        .buf_rdy_i      (buf_rdy),
        .issue_valid_o  (issue_valid),
        .issue_o        (issue)
    );

    exe_stage execute (
        .issue_i  (issue),
        .result_o (exe_res)
    );

    exe_mem_reg exe_mem_register (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .push_i       (issue_valid),
        .entry_i      (exe_res),
        .rdy_o        (buf_rdy),
        .head_valid_o (head_valid),
        .head_o       (head),
        .pop_i        (mem_pop)
    );

    mem_stage memory (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .head_valid_i   (head_valid),
        .head_i         (head),
        .pop_o          (mem_pop),
        .dmem_req_o     (dmem_req_o),
        .dmem_we_o      (dmem_we_o),
        .dmem_addr_o    (dmem_addr_o),
        .dmem_wdata_o   (dmem_wdata_o),
        .dmem_ack_i     (dmem_ack_i),
        .dmem_rdata_i   (dmem_rdata_i),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

endmodule

// File: source/rv_pipe_params.svh
`ifndef RV_PIPE_PARAMS_SVH
`define RV_PIPE_PARAMS_SVH

// datapath word width
`define RV_XLEN 32

// architectural integer registers, x0 included
`define RV_NUM_REGS 32

// entries in the execute/memory buffer, 4 works as well
`define RV_BUF_DEPTH 2

`endif

// File: source/rv_pipe_pkg.sv
package rv_pipe_pkg;

    `include "rv_pipe_params.svh"

    typedef logic [`RV_XLEN-1:0] rv_word_t;
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

    // major opcode field, instr[6:0]
    typedef enum logic [6:0] {
        OPC_LOAD  = 7'b0000011,
        OPC_IMM   = 7'b0010011,
        OPC_STORE = 7'b0100011,
        OPC_REG   = 7'b0110011,
        OPC_LUI   = 7'b0110111
    } rv_opcode_e;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LUI,
        OP_LOAD,
        OP_STORE,
        OP_NOP
    } alu_op_e;

    // four-phase req/ack phases
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_ACK,
        HS_WAIT_LOW
    } hs_state_e;

    typedef struct packed {
        alu_op_e  op;
        rv_word_t rs1_val;
        rv_word_t rs2_val;
        rv_word_t imm;
        reg_idx_t rd;
        logic     rd_we;
        logic     use_imm; // operand b from imm
    } issue_t;

    typedef struct packed {
        alu_op_e  op;
        rv_word_t result;     // alu result or data address
        rv_word_t store_data;
        reg_idx_t rd;
        logic     rd_we;
    } exe_mem_t;

    typedef struct packed {
        reg_idx_t rd;
        logic     rd_we;
        rv_word_t data;
    } retire_t;

endpackage

// File: sources.f
+incdir+source
source/rv_pipe_pkg.sv
source/decode_stage.sv
source/exe_stage.sv
source/exe_mem_reg.sv
source/mem_stage.sv
source/rv_datapath.sv
tb/rv_datapath_checker.sv
tb/rv_datapath_tb.sv

// File: tb/rv_datapath_checker.sv
`timescale 1ns/1ps

module rv_datapath_checker
    import rv_pipe_pkg::*;
(
    input logic     clk,
    input logic     arst_n_i,
    input logic     instr_req_i,
    input logic     instr_ack_o,
    input logic     dmem_req_o,
    input logic     dmem_we_o,
    input rv_word_t dmem_addr_o,
    input rv_word_t dmem_wdata_o,
    input logic     dmem_ack_i,
    input logic     retire_valid_o
);

    logic violation_seen = 1'b0; // sticky flag for any failing assertion

    dmem_fields_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        dmem_req_o && !dmem_ack_i |=> $stable({dmem_we_o, dmem_addr_o, dmem_wdata_o}))
    else begin
        $error("data port fields changed during an open request");
        violation_seen = 1'b1;
    end

    dmem_req_after_ack_low: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(dmem_req_o) |-> !$past(dmem_ack_i))
    else begin
        $error("data request raised while ack still high");
        violation_seen = 1'b1;
    end

    instr_ack_stays_low: assert property (@(posedge clk) disable iff (!arst_n_i)
        !instr_req_i && !instr_ack_o |=> !instr_ack_o)
    else begin
        $error("instruction ack rose without a request");
        violation_seen = 1'b1;
    end

    // outputs already cleared from the second reset cycle on
    reset_outputs_low: assert property (@(posedge clk)
        !arst_n_i && $past(!arst_n_i) |-> !retire_valid_o && !dmem_req_o && !instr_ack_o)
    else begin
        $error("handshake or retire output high during reset");
        violation_seen = 1'b1;
    end

endmodule

bind rv_datapath rv_datapath_checker protocol_checks (.*);

// File: tb/rv_datapath_tb.sv
`timescale 1ns/1ps
`include "rv_pipe_params.svh"

module rv_datapath_tb
    import rv_pipe_pkg::*;
();

    localparam int NUM_INSTR      = 300;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 12;
    localparam int MEM_WORDS      = 64;

    typedef struct packed {
        logic     we;
        rv_word_t addr;
        rv_word_t wdata;
    } dmem_txn_t;

    logic     clk;
    logic     arst_n_i;
    logic     instr_req_i;
    rv_word_t instr_i;
    logic     instr_ack_o;
    logic     dmem_req_o;
    logic     dmem_we_o;
    rv_word_t dmem_addr_o;
    rv_word_t dmem_wdata_o;
    logic     dmem_ack_i;
    rv_word_t dmem_rdata_i;
    logic     retire_valid_o;
    retire_t  retire_o;

    rv_word_t  prog [NUM_INSTR];
    rv_word_t  dmem [MEM_WORDS]; // upper address bits wrap
    retire_t   exp_retire [$];
    dmem_txn_t exp_txn [$];
    int        retired;
    int        issued;
    int        cycles;

    rv_datapath dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_run($sformatf("timeout: run not finished after %0d cycles", cycles));
            end
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_eq(input rv_word_t got, input rv_word_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at time %0t: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic rv_word_t fill_word(input int idx);
        return 32'h5a0f_3c00 ^ (idx * 32'h0101_0107);
    endfunction

    task automatic gen_program();
        int          kind;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        reg_idx_t    prev_rd;
        logic [11:0] imm;
        logic [19:0] upper;
        prev_rd = '0;
        for (int n = 0; n < NUM_INSTR; n++) begin
            kind  = $urandom_range(11, 0);
            rd    = $urandom_range(31, 0);
            rs1   = $urandom_range(31, 0);
            rs2   = $urandom_range(31, 0);
            imm   = $urandom;
            upper = $urandom;
            if (n >= 120 && n < 180) begin // raw chains and load-use pairs
                rd  = $urandom_range(31, 1);
                rs1 = prev_rd;
                rs2 = prev_rd;
                if (n % 3 == 0) begin
                    kind = 7;
                end
            end
            if (kind == 7 || kind == 8) begin
                imm = $urandom_range(MEM_WORDS - 1, 0);
            end
            case (kind)
                0:  prog[n] = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011}; // add
                1:  prog[n] = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011}; // sub
                2:  prog[n] = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011}; // and
                3:  prog[n] = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011}; // or
                4:  prog[n] = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011}; // xor
                5:  prog[n] = {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011}; // slt
                6:  prog[n] = {imm, rs1, 3'b000, rd, 7'b0010011};             // addi
                7:  prog[n] = {imm, rs1, 3'b010, rd, 7'b0000011};             // lw
                8:  prog[n] = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
                9:  prog[n] = {upper, rd, 7'b0110111};                         // lui
                10: prog[n] = {imm, upper[12:0], 7'b1100011};                  // branch
                default: prog[n] = {7'b0000000, rs2, rs1, 3'b011, rd, 7'b0110011};
            endcase
            prev_rd = rd;
        end
    endtask

    // in-order reference run that fills the expected queues
    task automatic run_model();
        rv_word_t  regs [`RV_NUM_REGS];
        rv_word_t  mem [MEM_WORDS];
        rv_word_t  ins;
        rv_word_t  a;
        rv_word_t  b;
        rv_word_t  imm_i;
        rv_word_t  imm_s;
        rv_word_t  val;
        logic      we;
        dmem_txn_t txn;
        retire_t   rec;
        for (int i = 0; i < `RV_NUM_REGS; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(i);
        end
        for (int n = 0; n < NUM_INSTR; n++) begin
            ins   = prog[n];
            a     = regs[ins[19:15]];
            b     = regs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            val   = '0;
            we    = 1'b1;
            case (ins[6:0])
                7'b0110011: begin
                    case ({ins[31:25], ins[14:12]})
                        10'b0000000_000: val = a + b;
                        10'b0100000_000: val = a - b;
                        10'b0000000_111: val = a & b;
                        10'b0000000_110: val = a | b;
                        10'b0000000_100: val = a ^ b;
                        10'b0000000_010: val = {31'b0, $signed(a) < $signed(b)};
                        default:         we  = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    we  = (ins[14:12] == 3'b000);
                    val = a + imm_i;
                end
                7'b0110111: val = {ins[31:12], 12'b0};
                7'b0000011: begin
                    we = (ins[14:12] == 3'b010);
                    if (we) begin
                        txn = '{we: 1'b0, addr: a + imm_i, wdata: '0};
                        exp_txn.push_back(txn);
                        val = mem[txn.addr % MEM_WORDS];
                    end
                end
                7'b0100011: begin
                    we = 1'b0;
                    if (ins[14:12] == 3'b010) begin
                        txn = '{we: 1'b1, addr: a + imm_s, wdata: b};
                        exp_txn.push_back(txn);
                        mem[txn.addr % MEM_WORDS] = b;
                    end
                end
                default: we = 1'b0;
            endcase
            we = we && (ins[11:7] != 5'd0); // x0 stays zero
            if (we) begin
                regs[ins[11:7]] = val;
            end
            rec.rd    = ins[11:7];
            rec.rd_we = we;
            rec.data  = val;
            exp_retire.push_back(rec);
        end
    endtask

    task automatic drive_instructions();
        for (int n = 0; n < NUM_INSTR; n++) begin
            instr_i     = prog[n];
            instr_req_i = 1'b1;
            do begin
                step_cycle();
            end while (!instr_ack_o); // stalls just hold the request
            issued++;
            instr_req_i = 1'b0;
            do begin
                step_cycle();
            end while (instr_ack_o);
            repeat ($urandom_range(2, 0)) begin
                step_cycle();
            end
        end
    endtask

    task automatic serve_data_memory();
        dmem_txn_t exp;
        int        served;
        int        delay;
        served = 0;
        forever begin
            step_cycle();
            if (dmem_req_o) begin
                if (exp_txn.size() == 0) begin
                    abort_run("data port request arrived with no access expected");
                end
                exp = exp_txn.pop_front();
                check_eq(dmem_we_o, exp.we, $sformatf("dmem %0d write flag", served));
                check_eq(dmem_addr_o, exp.addr, $sformatf("dmem %0d address", served));
                if (exp.we) begin
                    check_eq(dmem_wdata_o, exp.wdata, $sformatf("dmem %0d data", served));
                end
                // slow window lets the buffer fill up
                if (served >= 30 && served < 60) begin
                    delay = $urandom_range(10, 6);
                end else begin
                    delay = $urandom_range(3, 0);
                end
                repeat (delay) begin
                    step_cycle();
                end
                if (dmem_we_o) begin
                    dmem[dmem_addr_o % MEM_WORDS] = dmem_wdata_o;
                end else begin
                    dmem_rdata_i = dmem[dmem_addr_o % MEM_WORDS];
                end
                dmem_ack_i = 1'b1;
                do begin
                    step_cycle();
                end while (dmem_req_o);
                dmem_ack_i = 1'b0;
                served++;
            end
        end
    endtask

    task automatic monitor_retire();
        retire_t exp;
        forever begin
            step_cycle();
            if (dut.protocol_checks.violation_seen) begin
                abort_run("a protocol assertion in the bound checker failed");
            end
            if (retire_valid_o) begin
                if (retired >= issued || exp_retire.size() == 0) begin
                    abort_run("retire pulse without an accepted instruction");
                end
                exp = exp_retire.pop_front();
                check_eq(retire_o.rd_we, exp.rd_we, $sformatf("retire %0d we", retired));
                if (exp.rd_we) begin
                    check_eq(retire_o.rd, exp.rd, $sformatf("retire %0d rd", retired));
                    check_eq(retire_o.data, exp.data, $sformatf("retire %0d data", retired));
                end
                retired++;
            end
        end
    endtask

    initial begin
        void'($urandom(32'hb931));
        arst_n_i     = 1'b0;
        instr_req_i  = 1'b0;
        instr_i      = '0;
        dmem_ack_i   = 1'b0;
        dmem_rdata_i = '0;
        retired      = 0;
        issued       = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = fill_word(i);
        end
        gen_program();
        run_model();
        repeat (3) @(posedge clk);
        #1;
        check_eq(instr_ack_o, 1'b0, "instr_ack_o in reset");
        check_eq(dmem_req_o, 1'b0, "dmem_req_o in reset");
        check_eq(retire_valid_o, 1'b0, "retire_valid_o in reset");
        arst_n_i = 1'b1;
        fork
            drive_instructions();
            serve_data_memory();
            monitor_retire();
        join_none
        while (retired < NUM_INSTR) begin
            step_cycle();
        end
        repeat (20) begin
            step_cycle(); // catch stray retires
        end
        check_eq(exp_txn.size(), 0, "data port accesses left over");
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
